// ==== design/up_bus_pkg.sv ====
// internal register bus word types, request and reply structs, register bank sizes

package up_bus_pkg;

   // data word carried on the internal bus
   typedef logic [31:0] bus_word_t;

   // register address as sent in the command packet
   typedef logic [7:0] reg_addr_t;

   // register bank behind the bridge
   localparam int NUM_REGS = 16;

   // index bits needed to select one register
   localparam int REG_IDX_W = $clog2(NUM_REGS);

   // request from the bridge to the slave
   // rw set means write
   typedef struct packed {
      logic      rw;
      reg_addr_t reg_address;
      bus_word_t wdata;
   } bus_req_t;

   // reply from the slave, one cycle after the request
   // rdata is zero when the address is out of range
   typedef struct packed {
      bus_word_t rdata;
      logic      addr_error;
   } bus_rsp_t;

endpackage

// ==== design/up_packet_pkg.sv ====
// microcontroller packet layout, command byte fields and response status codes

package up_packet_pkg;

   // one byte on the microcontroller port
   typedef logic [7:0] up_byte_t;

   // inbound command packet: cmd, address, four data bytes
   localparam int NOS_READ_BYTES = 6;

   // outbound response packet: four data bytes, then status
   localparam int NOS_WRITE_BYTES = 5;

   // byte positions in the inbound packet
   localparam int CMD_REG  = 0;
   localparam int ADDR_REG = 1;
   // write data starts here, least significant byte first
   localparam int DATA_REG = 2;

   // byte position of the status in the outbound packet
   localparam int UP_STATUS_REG = 4;

   // command byte, bit 7 soft reset, bit 0 read/write
   typedef struct packed {
      logic       soft_reset;
      logic [5:0] reserved;
      logic       rw;
   } cmd_byte_t;

   // status byte values
   localparam up_byte_t STATUS_OK       = 8'h00;
   localparam up_byte_t STATUS_BAD_ADDR = 8'h0e;
   localparam up_byte_t RESET_CMD_DONE  = 8'h80;

endpackage

// ==== design/up_link_fsm.sv ====
// control FSM for the microcontroller strobes, bus request and soft reset sequence

`timescale 1ns/1ps

module up_link_fsm (
   input  logic clk,
   input  logic reset,
   input  logic up_start,
   input  logic up_handshake_1,
   input  logic soft_reset_cmd,
   input  logic counter_zero,
   input  logic bus_rsp_strobe,
   output logic up_ack,
   output logic up_handshake_2,
   output logic set_in_byte_count,
   output logic set_out_byte_count,
   output logic read_up_byte,
   output logic write_up_byte,
   output logic read_bus_word,
   output logic clear_up_packet,
   output logic bus_req_strobe,
   output logic slave_clear
);

   typedef enum logic [2:0] {
      idle,
      ack,
      receive,
      issue,
      wait_reply,
      send,
      wait_confirm
   } state_t;

   state_t state;
   state_t next_state;

   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= idle;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state         = state;
      up_ack             = 1'b0;
      up_handshake_2     = 1'b0;
      set_in_byte_count  = 1'b0;
      set_out_byte_count = 1'b0;
      read_up_byte       = 1'b0;
      write_up_byte      = 1'b0;
      read_bus_word      = 1'b0;
      clear_up_packet    = 1'b0;
      bus_req_strobe     = 1'b0;
      slave_clear        = 1'b0;
      case (state)
         idle: begin
            if (up_start) begin
               next_state = ack;
            end
         end
         ack: begin
            up_ack            = 1'b1;
            set_in_byte_count = 1'b1;
            next_state        = receive;
         end
         receive: begin
            // extra strobes after the last byte are ignored
            read_up_byte = up_handshake_1 && !counter_zero;
            if (counter_zero) begin
               next_state = issue;
            end
         end
         issue: begin
            if (soft_reset_cmd) begin
               // no bus transfer, clear the slave and answer directly
               slave_clear        = 1'b1;
               clear_up_packet    = 1'b1;
               set_out_byte_count = 1'b1;
               next_state         = send;
            end else begin
               bus_req_strobe = 1'b1;
               next_state     = wait_reply;
            end
         end
         wait_reply: begin
            if (bus_rsp_strobe) begin
               read_bus_word      = 1'b1;
               set_out_byte_count = 1'b1;
               next_state         = send;
            end
         end
         send: begin
            if (counter_zero) begin
               next_state = idle;
            end else begin
               up_handshake_2 = 1'b1;
               next_state     = wait_confirm;
            end
         end
         wait_confirm: begin
            // hold the byte until the microcontroller takes it
            if (up_handshake_1) begin
               write_up_byte = 1'b1;
               next_state    = send;
            end
         end
         default: begin
            next_state = idle;
         end
      endcase
   end

   a_single_req: assert property (@(posedge clk) disable iff (!reset)
      bus_req_strobe |=> !bus_req_strobe);

   // no outbound byte may be offered until the slave has answered
   a_no_send_while_pending: assert property (@(posedge clk) disable iff (!reset)
      bus_req_strobe |-> (!up_handshake_2 until_with bus_rsp_strobe));

endmodule

// ==== design/up_interface.sv ====
// bridge datapath with byte counter, packet stores and bus request assembly

`timescale 1ns/1ps

module up_interface (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   up_start,
   input  logic                   up_handshake_1,
   input  up_packet_pkg::up_byte_t up_data_out,
   input  up_bus_pkg::bus_rsp_t   bus_rsp,
   input  logic                   bus_rsp_strobe,
   output logic                   up_ack,
   output logic                   up_handshake_2,
   output up_packet_pkg::up_byte_t up_data_in,
   output up_bus_pkg::bus_req_t   bus_req,
   output logic                   bus_req_strobe,
   output logic                   slave_clear
);

   logic set_in_byte_count;
   logic set_out_byte_count;
   logic read_up_byte;
   logic write_up_byte;
   logic read_bus_word;
   logic clear_up_packet;
   logic soft_reset_cmd;
   logic counter_zero;

   // byte position in the current packet and bytes still to move
   logic [2:0] byte_count;
   logic [2:0] remaining;
   logic       out_phase;

   up_packet_pkg::up_byte_t  in_packet [up_packet_pkg::NOS_READ_BYTES];
   up_packet_pkg::up_byte_t  out_packet [up_packet_pkg::NOS_WRITE_BYTES];
   up_packet_pkg::cmd_byte_t cmd;

   up_link_fsm u_up_link_fsm (
      .clk                (clk),
      .reset              (reset),
      .up_start           (up_start),
      .up_handshake_1     (up_handshake_1),
      .soft_reset_cmd     (soft_reset_cmd),
      .counter_zero       (counter_zero),
      .bus_rsp_strobe     (bus_rsp_strobe),
      .up_ack             (up_ack),
      .up_handshake_2     (up_handshake_2),
      .set_in_byte_count  (set_in_byte_count),
      .set_out_byte_count (set_out_byte_count),
      .read_up_byte       (read_up_byte),
      .write_up_byte      (write_up_byte),
      .read_bus_word      (read_bus_word),
      .clear_up_packet    (clear_up_packet),
      .bus_req_strobe     (bus_req_strobe),
      .slave_clear        (slave_clear)
   );

   always_ff @(posedge clk) begin
      if (!reset) begin
         byte_count <= '0;
         remaining  <= '0;
         out_phase  <= 1'b0;
      end else if (set_in_byte_count) begin
         byte_count <= '0;
         remaining  <= 3'(up_packet_pkg::NOS_READ_BYTES);
         out_phase  <= 1'b0;
      end else if (set_out_byte_count) begin
         byte_count <= '0;
         remaining  <= 3'(up_packet_pkg::NOS_WRITE_BYTES);
         out_phase  <= 1'b1;
      end else if (read_up_byte || write_up_byte) begin
         byte_count <= byte_count + 3'd1;
         remaining  <= remaining - 3'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (read_up_byte) begin
         in_packet[byte_count] <= up_data_out;
      end
   end

   // reply word goes out least significant byte first
   always_ff @(posedge clk) begin
      if (read_bus_word) begin
         out_packet[0] <= bus_rsp.rdata[7:0];
         out_packet[1] <= bus_rsp.rdata[15:8];
         out_packet[2] <= bus_rsp.rdata[23:16];
         out_packet[3] <= bus_rsp.rdata[31:24];
         out_packet[up_packet_pkg::UP_STATUS_REG] <= bus_rsp.addr_error ?
            up_packet_pkg::STATUS_BAD_ADDR : up_packet_pkg::STATUS_OK;
      end else if (clear_up_packet) begin
         for (int i = 0; i < up_packet_pkg::UP_STATUS_REG; i++) begin
            out_packet[i] <= '0;
         end
         out_packet[up_packet_pkg::UP_STATUS_REG] <= up_packet_pkg::RESET_CMD_DONE;
      end
   end

   assign counter_zero = (remaining == 3'd0);

   assign up_data_in = (byte_count < 3'(up_packet_pkg::NOS_WRITE_BYTES)) ?
                       out_packet[byte_count] : '0;

   assign cmd            = up_packet_pkg::cmd_byte_t'(in_packet[up_packet_pkg::CMD_REG]);
   assign soft_reset_cmd = cmd.soft_reset;

   assign bus_req.rw          = cmd.rw;
   assign bus_req.reg_address = in_packet[up_packet_pkg::ADDR_REG];
   assign bus_req.wdata       = {in_packet[up_packet_pkg::DATA_REG + 3],
                                 in_packet[up_packet_pkg::DATA_REG + 2],
                                 in_packet[up_packet_pkg::DATA_REG + 1],
                                 in_packet[up_packet_pkg::DATA_REG]};

   a_count_in_range: assert property (@(posedge clk) disable iff (!reset)
      byte_count <= (out_phase ? 3'(up_packet_pkg::NOS_WRITE_BYTES)
                               : 3'(up_packet_pkg::NOS_READ_BYTES)));

endmodule

// ==== design/reg_bank_slave.sv ====
// sixteen-word register slave with range check, registered reply and soft clear

`timescale 1ns/1ps

module reg_bank_slave (
   input  logic                 clk,
   input  logic                 reset,
   input  up_bus_pkg::bus_req_t bus_req,
   input  logic                 bus_req_strobe,
   input  logic                 slave_clear,
   output up_bus_pkg::bus_rsp_t bus_rsp,
   output logic                 bus_rsp_strobe
);

   up_bus_pkg::bus_word_t regs [up_bus_pkg::NUM_REGS];

   logic                             addr_ok;
   logic [up_bus_pkg::REG_IDX_W-1:0] idx;

   assign addr_ok = bus_req.reg_address < up_bus_pkg::reg_addr_t'(up_bus_pkg::NUM_REGS);
   assign idx     = bus_req.reg_address[up_bus_pkg::REG_IDX_W-1:0];

   // soft clear from the bridge behaves like reset for the bank
   always_ff @(posedge clk) begin
      if (!reset || slave_clear) begin
         for (int i = 0; i < up_bus_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (bus_req_strobe && bus_req.rw && addr_ok) begin
         regs[idx] <= bus_req.wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         bus_rsp_strobe <= 1'b0;
      end else begin
         bus_rsp_strobe <= bus_req_strobe;
      end
   end

   // a write answers with the value just stored
   always_ff @(posedge clk) begin
      if (bus_req_strobe) begin
         if (!addr_ok) begin
            bus_rsp <= '{rdata: '0, addr_error: 1'b1};
         end else if (bus_req.rw) begin
            bus_rsp <= '{rdata: bus_req.wdata, addr_error: 1'b0};
         end else begin
            bus_rsp <= '{rdata: regs[idx], addr_error: 1'b0};
         end
      end
   end

   // request must hold until the reply, which comes one cycle later
   a_reply_next_cycle: assert property (@(posedge clk) disable iff (!reset)
      bus_req_strobe |=> bus_rsp_strobe && $stable(bus_req));

endmodule

// ==== design/up_subsystem.sv ====
// top level joining the microcontroller bridge and the register slave

`timescale 1ns/1ps

module up_subsystem (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    up_start,
   input  logic                    up_handshake_1,
   input  up_packet_pkg::up_byte_t up_data_out,
   output logic                    up_ack,
   output logic                    up_handshake_2,
   output up_packet_pkg::up_byte_t up_data_in
);

   up_bus_pkg::bus_req_t bus_req;
   up_bus_pkg::bus_rsp_t bus_rsp;
   logic                 bus_req_strobe;
   logic                 bus_rsp_strobe;
   logic                 slave_clear;

   up_interface u_up_interface (
      .clk            (clk),
      .reset          (reset),
      .up_start       (up_start),
      .up_handshake_1 (up_handshake_1),
      .up_data_out    (up_data_out),
      .bus_rsp        (bus_rsp),
      .bus_rsp_strobe (bus_rsp_strobe),
      .up_ack         (up_ack),
      .up_handshake_2 (up_handshake_2),
      .up_data_in     (up_data_in),
      .bus_req        (bus_req),
      .bus_req_strobe (bus_req_strobe),
      .slave_clear    (slave_clear)
   );

   reg_bank_slave u_reg_bank_slave (
      .clk            (clk),
      .reset          (reset),
      .bus_req        (bus_req),
      .bus_req_strobe (bus_req_strobe),
      .slave_clear    (slave_clear),
      .bus_rsp        (bus_rsp),
      .bus_rsp_strobe (bus_rsp_strobe)
   );

endmodule

// ==== bench/up_subsystem_tb.sv ====
// testbench for up_subsystem with stimulus table, reference model, LFSR and compare tasks

`timescale 1ns/1ps

module up_subsystem_tb;

   localparam int TIMEOUT_CYCLES = 50;
   localparam int NUM_ROWS       = 16;

   typedef struct packed {
      up_packet_pkg::up_byte_t cmd;
      up_bus_pkg::reg_addr_t   addr;
      up_bus_pkg::bus_word_t   data;
      logic                    rand_data;
      logic                    rand_gap;
   } stim_t;

   // cmd, address, write data, data from LFSR, random pacing
   stim_t stim_table [NUM_ROWS] = '{
      '{8'h00, 8'h05, 32'h0000_0000, 1'b0, 1'b0},
      '{8'h01, 8'h03, 32'hdead_beef, 1'b0, 1'b0},
      '{8'h00, 8'h03, 32'h0000_0000, 1'b0, 1'b0},
      '{8'h01, 8'h0c, 32'h0000_0000, 1'b1, 1'b1},
      '{8'h01, 8'h0f, 32'h0bad_cafe, 1'b0, 1'b0},
      '{8'h01, 8'h10, 32'h1234_5678, 1'b0, 1'b1},
      '{8'h00, 8'hff, 32'h0000_0000, 1'b0, 1'b0},
      '{8'h00, 8'h00, 32'h0000_0000, 1'b0, 1'b1},
      '{8'h00, 8'h03, 32'h0000_0000, 1'b0, 1'b1},
      '{8'h00, 8'h0c, 32'h0000_0000, 1'b0, 1'b1},
      '{8'h81, 8'h03, 32'hffff_ffff, 1'b0, 1'b0},
      '{8'h00, 8'h03, 32'h0000_0000, 1'b0, 1'b0},
      '{8'h00, 8'h0c, 32'h0000_0000, 1'b0, 1'b1},
      '{8'h00, 8'h0f, 32'h0000_0000, 1'b0, 1'b0},
      '{8'h01, 8'h07, 32'h0000_0000, 1'b1, 1'b1},
      '{8'h00, 8'h07, 32'h0000_0000, 1'b0, 1'b1}
   };

   logic                    clk;
   logic                    reset;
   logic                    up_start;
   logic                    up_handshake_1;
   up_packet_pkg::up_byte_t up_data_out;
   logic                    up_ack;
   logic                    up_handshake_2;
   up_packet_pkg::up_byte_t up_data_in;

   up_bus_pkg::bus_word_t model [up_bus_pkg::NUM_REGS];
   logic [31:0]           lfsr_state = 32'h9882f72f;
   int                    errors;
   int                    timeouts;
   int                    ack_count;
   int                    txn_count;
   bit                    in_txn;

   up_subsystem u_up_subsystem (
      .clk            (clk),
      .reset          (reset),
      .up_start       (up_start),
      .up_handshake_1 (up_handshake_1),
      .up_data_out    (up_data_out),
      .up_ack         (up_ack),
      .up_handshake_2 (up_handshake_2),
      .up_data_in     (up_data_in)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // taps 32 22 2 1, one step per bit taken
   function automatic logic [31:0] lfsr_take(input int nbits);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < nbits; i++) begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         val        = {val[30:0], fb};
      end
      return val;
   endfunction

   task automatic check_byte(input string name, input up_packet_pkg::up_byte_t exp,
                             input up_packet_pkg::up_byte_t act);
      if (exp !== act) begin
         errors++;
         $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      end
   endtask

   task automatic check_status(input up_packet_pkg::up_byte_t exp,
                               input up_packet_pkg::up_byte_t act);
      if (exp !== act) begin
         errors++;
         $display("ERR time=%0t signal=status expected=%h actual=%h", $time, exp, act);
      end
   endtask

   task automatic check_word(input up_bus_pkg::bus_word_t exp, input up_bus_pkg::bus_word_t act);
      if (exp !== act) begin
         errors++;
         $display("ERR time=%0t signal=rdata expected=%h actual=%h", $time, exp, act);
      end
   endtask

   // outputs are sampled on the falling edge
   task automatic wait_for_ack(output bit ok);
      int n;
      n  = 0;
      ok = 1'b0;
      while (!ok && n < TIMEOUT_CYCLES) begin
         @(negedge clk);
         ok = up_ack;
         n++;
      end
      if (!ok) begin
         timeouts++;
         $display("timeout at %0t: up_ack never came after up_start", $time);
      end
   endtask

   task automatic wait_for_hs2(output bit ok);
      int n;
      n  = 0;
      ok = 1'b0;
      while (!ok && n < TIMEOUT_CYCLES) begin
         @(negedge clk);
         ok = up_handshake_2;
         n++;
      end
      if (!ok) begin
         timeouts++;
         $display("timeout at %0t: up_handshake_2 never marked a response byte", $time);
      end
   endtask

   task automatic run_txn(input up_packet_pkg::up_byte_t cmd, input up_bus_pkg::reg_addr_t addr,
                          input up_bus_pkg::bus_word_t wdata, input logic rand_gap);
      up_packet_pkg::up_byte_t  pkt [up_packet_pkg::NOS_READ_BYTES];
      up_packet_pkg::up_byte_t  rsp [up_packet_pkg::NOS_WRITE_BYTES];
      up_packet_pkg::cmd_byte_t cmd_f;
      up_bus_pkg::bus_word_t    exp_word;
      up_packet_pkg::up_byte_t  exp_status;
      bit                       ok;
      int                       gap;
      cmd_f = up_packet_pkg::cmd_byte_t'(cmd);
      pkt[up_packet_pkg::CMD_REG]  = cmd;
      pkt[up_packet_pkg::ADDR_REG] = addr;
      for (int i = 0; i < 4; i++) begin
         pkt[up_packet_pkg::DATA_REG + i] = wdata[8*i +: 8];
      end
      if (cmd_f.soft_reset) begin
         for (int k = 0; k < up_bus_pkg::NUM_REGS; k++) begin
            model[k] = '0;
         end
         exp_word   = '0;
         exp_status = up_packet_pkg::RESET_CMD_DONE;
      end else if (addr >= up_bus_pkg::NUM_REGS) begin
         exp_word   = '0;
         exp_status = up_packet_pkg::STATUS_BAD_ADDR;
      end else begin
         if (cmd_f.rw) begin
            model[addr] = wdata;
         end
         exp_word   = model[addr];
         exp_status = up_packet_pkg::STATUS_OK;
      end
      @(posedge clk);
      up_start <= 1'b1;
      in_txn = 1'b1;
      txn_count++;
      wait_for_ack(ok);
      if (!ok) return;
      for (int i = 0; i < up_packet_pkg::NOS_READ_BYTES; i++) begin
         @(posedge clk);
         up_start       <= 1'b0;
         up_handshake_1 <= 1'b1;
         up_data_out    <= pkt[i];
         @(posedge clk);
         up_handshake_1 <= 1'b0;
         gap = (rand_gap && i < up_packet_pkg::NOS_READ_BYTES - 1) ? lfsr_take(2) : 0;
         repeat (gap) @(posedge clk);
      end
      // delayed confirmations hold each byte in place
      for (int i = 0; i < up_packet_pkg::NOS_WRITE_BYTES; i++) begin
         wait_for_hs2(ok);
         if (!ok) return;
         rsp[i] = up_data_in;
         gap = rand_gap ? lfsr_take(2) : 0;
         repeat (gap) @(posedge clk);
         @(posedge clk);
         up_handshake_1 <= 1'b1;
         @(posedge clk);
         up_handshake_1 <= 1'b0;
      end
      in_txn = 1'b0;
      for (int i = 0; i < 4; i++) begin
         check_byte($sformatf("up_data_in[%0d]", i), exp_word[8*i +: 8], rsp[i]);
      end
      check_word(exp_word, {rsp[3], rsp[2], rsp[1], rsp[0]});
      check_status(exp_status, rsp[up_packet_pkg::UP_STATUS_REG]);
   endtask

   always @(negedge clk) begin
      if (reset) begin
         if (up_ack) begin
            ack_count++;
         end
         if (up_handshake_2 && !in_txn) begin
            errors++;
            $display("up_handshake_2 went high between transactions at %0t", $time);
         end
      end
   end

   initial begin
      stim_t                 row;
      up_bus_pkg::bus_word_t wdata;
      reset          = 1'b0;
      up_start       = 1'b0;
      up_handshake_1 = 1'b0;
      up_data_out    = '0;
      for (int k = 0; k < up_bus_pkg::NUM_REGS; k++) begin
         model[k] = '0;
      end
      repeat (5) @(posedge clk);
      reset <= 1'b1;
      for (int r = 0; r < NUM_ROWS && timeouts == 0; r++) begin
         row   = stim_table[r];
         wdata = row.rand_data ? lfsr_take(32) : row.data;
         run_txn(row.cmd, row.addr, wdata, row.rand_gap);
      end
      // read the whole bank back
      for (int a = 0; a < up_bus_pkg::NUM_REGS && timeouts == 0; a++) begin
         run_txn(8'h00, up_bus_pkg::reg_addr_t'(a), '0, 1'b1);
      end
      repeat (3) @(posedge clk);
      if (timeouts == 0 && ack_count != txn_count) begin
         errors++;
         $display("up_ack pulsed %0d times for %0d starts", ack_count, txn_count);
      end
      $display("errors=%0d timeouts=%0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
design/up_bus_pkg.sv
design/up_packet_pkg.sv
design/up_link_fsm.sv
design/up_interface.sv
design/reg_bank_slave.sv
design/up_subsystem.sv
bench/up_subsystem_tb.sv
